/* design/zynq_shim_macros.svh */
`ifndef ZYNQ_SHIM_MACROS_SVH
`define ZYNQ_SHIM_MACROS_SVH

// processor physical address width
`define ZS_PADDR_W      32

// processor DRAM starts at 0x8000_0000, so only the high bit is set
`define ZS_DRAM_BASE    32'h8000_0000

// the host only hands out 256 MB to the processor
`define ZS_MEM_LIMIT    32'h1000_0000

// each usage-map bit covers one 8 MB slice of the processor address
`define ZS_REGION_MSB   29
`define ZS_REGION_W     7
`define ZS_PROFILE_W    128

// host register file geometry
`define ZS_CSR_ADDR_W   3
`define ZS_CSR_DATA_W   32

// register 0 is the soft reset, low true
`define ZS_CSR_RESET    0
`define ZS_CSR_ALLOC    1
`define ZS_CSR_BASE     2

// indices 4 to 7 read the usage map, lowest word first
`define ZS_CSR_PROF0    4

// default depth of the request buffer
`define ZS_FIFO_DEPTH   4

`endif

/* design/zynq_shim_pkg.sv */
`include "zynq_shim_macros.svh"

`default_nettype none

package zynq_shim_pkg;

   // address in the processor or host physical space
   typedef logic [`ZS_PADDR_W-1:0]    paddr_t;

   // index of one usage-map slice
   typedef logic [`ZS_REGION_W-1:0]   region_t;

   typedef logic [`ZS_CSR_ADDR_W-1:0] csr_addr_t;
   typedef logic [`ZS_CSR_DATA_W-1:0] csr_data_t;

   // one bit per region of DRAM touched by the processor
   typedef logic [`ZS_PROFILE_W-1:0]  profile_t;

   // request as it leaves the processor
   typedef struct packed {
      logic   wr;
      paddr_t addr;
   } bp_req_s;

   // decoded request, offset already relative to the DRAM window
   typedef struct packed {
      logic    wr;
      paddr_t  offset;
      region_t region;
      logic    over_limit;
   } mem_pkt_s;

   // request presented to the host memory port
   typedef struct packed {
      logic   wr;
      paddr_t addr;
      logic   over_limit;
   } dram_req_s;

endpackage

`default_nettype wire

/* design/ps_csr_regs.sv */
`include "zynq_shim_macros.svh"

`default_nettype none

module ps_csr_regs (
   input  wire logic                     aclk_i,
   input  wire logic                     arst_n_i,
   input  wire logic                     csr_wr_v_i,
   input  wire zynq_shim_pkg::csr_addr_t csr_addr_i,
   input  wire zynq_shim_pkg::csr_data_t csr_wdata_i,
   input  wire zynq_shim_pkg::csr_addr_t csr_rd_addr_i,
   input  wire zynq_shim_pkg::profile_t  profile_i,
   output zynq_shim_pkg::csr_data_t      csr_rdata_o,
   output zynq_shim_pkg::csr_data_t      dram_base_o,
   output logic                          core_reset_o
);

   zynq_shim_pkg::csr_data_t reset_r;
   zynq_shim_pkg::csr_data_t alloc_r;
   zynq_shim_pkg::csr_data_t base_r;

   // word offset into the usage map for read indices 4 to 7
   logic [1:0] prof_word;

   always_ff @(posedge aclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         reset_r <= '0;
         alloc_r <= '0;
         base_r  <= '0;
      end else if (csr_wr_v_i) begin
         case (csr_addr_i)
            zynq_shim_pkg::csr_addr_t'(`ZS_CSR_RESET): reset_r <= csr_wdata_i;
            zynq_shim_pkg::csr_addr_t'(`ZS_CSR_ALLOC): alloc_r <= csr_wdata_i;
            zynq_shim_pkg::csr_addr_t'(`ZS_CSR_BASE):  base_r  <= csr_wdata_i;
            default: ;
         endcase
      end
   end

   // the core stays held until the host sets bit 0, so it comes up in reset
   assign core_reset_o = ~reset_r[0];
   assign dram_base_o  = base_r;

   assign prof_word = 2'(csr_rd_addr_i - zynq_shim_pkg::csr_addr_t'(`ZS_CSR_PROF0));

   always_comb begin
      csr_rdata_o = '0;
      if (csr_rd_addr_i >= zynq_shim_pkg::csr_addr_t'(`ZS_CSR_PROF0)) begin
         csr_rdata_o = profile_i[prof_word*`ZS_CSR_DATA_W +: `ZS_CSR_DATA_W];
      end else begin
         case (csr_rd_addr_i)
            zynq_shim_pkg::csr_addr_t'(`ZS_CSR_RESET): csr_rdata_o = reset_r;
            zynq_shim_pkg::csr_addr_t'(`ZS_CSR_ALLOC): csr_rdata_o = alloc_r;
            zynq_shim_pkg::csr_addr_t'(`ZS_CSR_BASE):  csr_rdata_o = base_r;
            // index 3 is unused and reads zero
            default: csr_rdata_o = '0;
         endcase
      end
   end

endmodule

`default_nettype wire

/* design/mem_req_intake.sv */
`include "zynq_shim_macros.svh"

`default_nettype none

module mem_req_intake (
   input  wire logic                   aclk_i,
   input  wire logic                   arst_n_i,
   input  wire logic                   bp_req_v_i,
   input  wire zynq_shim_pkg::bp_req_s bp_req_i,
   input  wire logic                   pkt_ready_i,
   output logic                        bp_req_ready_o,
   output logic                        pkt_v_o,
   output zynq_shim_pkg::mem_pkt_s     pkt_o
);

   zynq_shim_pkg::paddr_t   offset;
   zynq_shim_pkg::mem_pkt_s pkt_next;
   zynq_shim_pkg::mem_pkt_s pkt_r;
   logic                    pkt_v_r;
   logic                    accept;

   // flipping bit 31 is the same as subtracting the processor DRAM base
   assign offset = bp_req_i.addr ^ zynq_shim_pkg::paddr_t'(`ZS_DRAM_BASE);

   always_comb begin
      pkt_next.wr         = bp_req_i.wr;
      pkt_next.offset     = offset;
      pkt_next.region     = bp_req_i.addr[`ZS_REGION_MSB -: `ZS_REGION_W];
      // anything past 256 MB falls outside what the host allocated
      pkt_next.over_limit = (offset >= zynq_shim_pkg::paddr_t'(`ZS_MEM_LIMIT));
   end

   // the slot frees up in the same cycle its packet is taken downstream
   // and nothing is accepted while the shim sits in reset
   assign bp_req_ready_o = arst_n_i & (~pkt_v_r | pkt_ready_i);
   assign accept         = bp_req_v_i & bp_req_ready_o;

   always_ff @(posedge aclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pkt_v_r <= 1'b0;
      end else if (accept) begin
         pkt_v_r <= 1'b1;
      end else if (pkt_ready_i) begin
         pkt_v_r <= 1'b0;
      end
   end

   always_ff @(posedge aclk_i) begin
      if (accept) begin
         pkt_r <= pkt_next;
      end
   end

   assign pkt_v_o = pkt_v_r;
   assign pkt_o   = pkt_r;

endmodule

`default_nettype wire

/* design/req_fifo.sv */
`include "zynq_shim_macros.svh"

`default_nettype none

module req_fifo #(
   parameter int DEPTH = `ZS_FIFO_DEPTH
) (
   input  wire logic                    aclk_i,
   input  wire logic                    arst_n_i,
   input  wire logic                    in_v_i,
   input  wire zynq_shim_pkg::mem_pkt_s in_i,
   input  wire logic                    out_ready_i,
   output logic                         in_ready_o,
   output logic                         out_v_o,
   output zynq_shim_pkg::mem_pkt_s      out_o
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   zynq_shim_pkg::mem_pkt_s mem_q [DEPTH];

   logic [PTR_W-1:0] wr_ptr_r;
   logic [PTR_W-1:0] rd_ptr_r;
   logic [CNT_W-1:0] count_r;
   logic             full;
   logic             push;
   logic             pop;

   // pointers wrap at DEPTH, which need not be a power of two
   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH - 1)) begin
         ptr_next = '0;
      end else begin
         ptr_next = ptr + 1'b1;
      end
   endfunction

   assign full    = (count_r == CNT_W'(DEPTH));
   assign out_v_o = (count_r != '0);
   assign out_o   = mem_q[rd_ptr_r];

   // when full, a write only goes in alongside a read of the head
   assign in_ready_o = ~full | out_ready_i;
   assign push       = in_v_i & in_ready_o;
   assign pop        = out_v_o & out_ready_i;

   always_ff @(posedge aclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
      end else begin
         if (push) begin
            wr_ptr_r <= ptr_next(wr_ptr_r);
         end
         if (pop) begin
            rd_ptr_r <= ptr_next(rd_ptr_r);
         end
         if (push && !pop) begin
            count_r <= count_r + 1'b1;
         end else if (pop && !push) begin
            count_r <= count_r - 1'b1;
         end
      end
   end

   always_ff @(posedge aclk_i) begin
      if (push) begin
         mem_q[wr_ptr_r] <= in_i;
      end
   end

endmodule

`default_nettype wire

/* design/dram_remap.sv */
`include "zynq_shim_macros.svh"

`default_nettype none

module dram_remap (
   input  wire logic                     aclk_i,
   input  wire logic                     arst_n_i,
   input  wire logic                     pkt_v_i,
   input  wire zynq_shim_pkg::mem_pkt_s  pkt_i,
   input  wire zynq_shim_pkg::csr_data_t dram_base_i,
   input  wire logic                     core_reset_i,
   input  wire logic                     dram_req_ready_i,
   output logic                          pkt_ready_o,
   output logic                          dram_req_v_o,
   output zynq_shim_pkg::dram_req_s      dram_req_o,
   output zynq_shim_pkg::profile_t       profile_o
);

   zynq_shim_pkg::dram_req_s req_next;
   zynq_shim_pkg::dram_req_s req_r;
   zynq_shim_pkg::region_t   region_r;
   zynq_shim_pkg::profile_t  profile_r;
   logic                     req_v_r;
   logic                     take;
   logic                     send;

   // relocate into the window the host allocated for the processor
   always_comb begin
      req_next.wr         = pkt_i.wr;
      req_next.addr       = pkt_i.offset + zynq_shim_pkg::paddr_t'(dram_base_i);
      req_next.over_limit = pkt_i.over_limit;
   end

   assign pkt_ready_o = ~req_v_r | dram_req_ready_i;
   assign take        = pkt_v_i & pkt_ready_o;
   assign send        = req_v_r & dram_req_ready_i;

   always_ff @(posedge aclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         req_v_r <= 1'b0;
      end else if (take) begin
         req_v_r <= 1'b1;
      end else if (dram_req_ready_i) begin
         req_v_r <= 1'b0;
      end
   end

   // the region travels beside the request so the map updates on the way out
   always_ff @(posedge aclk_i) begin
      if (take) begin
         req_r    <= req_next;
         region_r <= pkt_i.region;
      end
   end

   // the usage map only counts what the core did since it last left reset
   always_ff @(posedge aclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         profile_r <= '0;
      end else if (core_reset_i) begin
         profile_r <= '0;
      end else if (send) begin
         profile_r[region_r] <= 1'b1;
      end
   end

   assign dram_req_v_o = req_v_r;
   assign dram_req_o   = req_r;
   assign profile_o    = profile_r;

endmodule

`default_nettype wire

/* design/zynq_dram_shim.sv */
`include "zynq_shim_macros.svh"

`default_nettype none

module zynq_dram_shim (
   input  wire logic                     aclk_i,
   input  wire logic                     arst_n_i,
   input  wire logic                     csr_wr_v_i,
   input  wire zynq_shim_pkg::csr_addr_t csr_addr_i,
   input  wire zynq_shim_pkg::csr_data_t csr_wdata_i,
   input  wire zynq_shim_pkg::csr_addr_t csr_rd_addr_i,
   input  wire logic                     bp_req_v_i,
   input  wire zynq_shim_pkg::bp_req_s   bp_req_i,
   input  wire logic                     dram_req_ready_i,
   output zynq_shim_pkg::csr_data_t      csr_rdata_o,
   output logic                          core_reset_o,
   output logic                          bp_req_ready_o,
   output logic                          dram_req_v_o,
   output zynq_shim_pkg::dram_req_s      dram_req_o
);

   zynq_shim_pkg::csr_data_t dram_base;
   zynq_shim_pkg::profile_t  profile;

   // producer to buffer
   zynq_shim_pkg::mem_pkt_s  intake_pkt;
   logic                     intake_v;
   logic                     fifo_ready;

   // buffer to consumer
   zynq_shim_pkg::mem_pkt_s  fifo_pkt;
   logic                     fifo_v;
   logic                     remap_ready;

   ps_csr_regs u_csr (
      .aclk_i        (aclk_i),
      .arst_n_i      (arst_n_i),
      .csr_wr_v_i    (csr_wr_v_i),
      .csr_addr_i    (csr_addr_i),
      .csr_wdata_i   (csr_wdata_i),
      .csr_rd_addr_i (csr_rd_addr_i),
      .profile_i     (profile),
      .csr_rdata_o   (csr_rdata_o),
      .dram_base_o   (dram_base),
      .core_reset_o  (core_reset_o)
   );

   mem_req_intake u_intake (
      .aclk_i         (aclk_i),
      .arst_n_i       (arst_n_i),
      .bp_req_v_i     (bp_req_v_i),
      .bp_req_i       (bp_req_i),
      .pkt_ready_i    (fifo_ready),
      .bp_req_ready_o (bp_req_ready_o),
      .pkt_v_o        (intake_v),
      .pkt_o          (intake_pkt)
   );

   req_fifo #(
      .DEPTH (`ZS_FIFO_DEPTH)
   ) u_fifo (
      .aclk_i      (aclk_i),
      .arst_n_i    (arst_n_i),
      .in_v_i      (intake_v),
      .in_i        (intake_pkt),
      .out_ready_i (remap_ready),
      .in_ready_o  (fifo_ready),
      .out_v_o     (fifo_v),
      .out_o       (fifo_pkt)
   );

   dram_remap u_remap (
      .aclk_i           (aclk_i),
      .arst_n_i         (arst_n_i),
      .pkt_v_i          (fifo_v),
      .pkt_i            (fifo_pkt),
      .dram_base_i      (dram_base),
      .core_reset_i     (core_reset_o),
      .dram_req_ready_i (dram_req_ready_i),
      .pkt_ready_o      (remap_ready),
      .dram_req_v_o     (dram_req_v_o),
      .dram_req_o       (dram_req_o),
      .profile_o        (profile)
   );

endmodule

`default_nettype wire

/* verif/zynq_dram_shim_asserts.sv */
`include "zynq_shim_macros.svh"

`default_nettype none

module zynq_dram_shim_asserts (
   input wire logic                     aclk_i,
   input wire logic                     arst_n_i,
   input wire logic                     req_v_i,
   input wire zynq_shim_pkg::dram_req_s req_i,
   input wire logic                     req_ready_i,
   input wire logic                     bp_ready_i,
   input wire logic                     csr_wr_v_i,
   input wire zynq_shim_pkg::csr_addr_t csr_addr_i,
   input wire zynq_shim_pkg::csr_data_t csr_wdata_i,
   input wire logic                     core_reset_i
);

   logic reset_wr;

   assign reset_wr = csr_wr_v_i &&
      (csr_addr_i == zynq_shim_pkg::csr_addr_t'(`ZS_CSR_RESET));

   // a stalled host request must not change or vanish before it is taken
   dram_req_held: assert property (
      @(posedge aclk_i) disable iff (!arst_n_i)
      req_v_i && !req_ready_i |=> req_v_i && $stable(req_i)
   ) else $error("DRAM request changed or dropped before the host took it");

   // nothing is taken in or sent out while the shim is in reset
   idle_in_reset: assert property (
      @(posedge aclk_i) !arst_n_i |-> !req_v_i && !bp_ready_i
   ) else $error("request handshake active during reset");

   // clearing bit 0 of register 0 holds the core from the next edge
   core_held: assert property (
      @(posedge aclk_i) disable iff (!arst_n_i)
      reset_wr && !csr_wdata_i[0] |=> core_reset_i
   ) else $error("core left reset while register 0 bit 0 is low");

   // the soft reset only moves on a write to register 0
   core_reset_steady: assert property (
      @(posedge aclk_i) disable iff (!arst_n_i)
      !reset_wr |=> $stable(core_reset_i)
   ) else $error("core reset changed without a write to register 0");

endmodule

bind zynq_dram_shim zynq_dram_shim_asserts u_asserts (
   .aclk_i       (aclk_i),
   .arst_n_i     (arst_n_i),
   .req_v_i      (dram_req_v_o),
   .req_i        (dram_req_o),
   .req_ready_i  (dram_req_ready_i),
   .bp_ready_i   (bp_req_ready_o),
   .csr_wr_v_i   (csr_wr_v_i),
   .csr_addr_i   (csr_addr_i),
   .csr_wdata_i  (csr_wdata_i),
   .core_reset_i (core_reset_o)
);

`default_nettype wire

/* verif/zynq_dram_shim_tb.sv */
`include "zynq_shim_macros.svh"

`default_nettype none

module zynq_dram_shim_tb;

   localparam int CLK_PERIOD = 8;
   localparam int RESET_CYCLES = 16;
   localparam int NUM_REQ = 300;
   // 40 cycles per request, plus room for reset and the register phases
   localparam int WATCHDOG_CYCLES = NUM_REQ * 40 + RESET_CYCLES + 400;

   logic                      aclk;
   logic                      arst_n;
   logic                      csr_wr_v;
   zynq_shim_pkg::csr_addr_t  csr_addr;
   zynq_shim_pkg::csr_data_t  csr_wdata;
   zynq_shim_pkg::csr_addr_t  csr_rd_addr;
   logic                      bp_req_v;
   zynq_shim_pkg::bp_req_s    bp_req;
   logic                      dram_req_ready;
   zynq_shim_pkg::csr_data_t  csr_rdata;
   logic                      core_reset;
   logic                      bp_req_ready;
   logic                      dram_req_v;
   zynq_shim_pkg::dram_req_s  dram_req;

   logic [15:0]               lfsr_state = 16'd50720;
   logic                      rand_ready_en;
   zynq_shim_pkg::csr_data_t  base_val;
   zynq_shim_pkg::profile_t   exp_profile;
   zynq_shim_pkg::dram_req_s  exp_q [$];
   zynq_shim_pkg::region_t    region_q [$];
   zynq_shim_pkg::dram_req_s  exp_req;
   zynq_shim_pkg::region_t    exp_region;
   int                        errors;
   int                        checks;
   int                        accepted;
   int                        out_count;

   zynq_dram_shim dut (
      .aclk_i           (aclk),
      .arst_n_i         (arst_n),
      .csr_wr_v_i       (csr_wr_v),
      .csr_addr_i       (csr_addr),
      .csr_wdata_i      (csr_wdata),
      .csr_rd_addr_i    (csr_rd_addr),
      .bp_req_v_i       (bp_req_v),
      .bp_req_i         (bp_req),
      .dram_req_ready_i (dram_req_ready),
      .csr_rdata_o      (csr_rdata),
      .core_reset_o     (core_reset),
      .bp_req_ready_o   (bp_req_ready),
      .dram_req_v_o     (dram_req_v),
      .dram_req_o       (dram_req)
   );

   always #(CLK_PERIOD / 2) aclk = ~aclk;

   // 16-bit Galois LFSR, one step per bit handed out
   function automatic logic lfsr_bit();
      logic out;
      out = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out) begin
         lfsr_state = lfsr_state ^ 16'hB400;
      end
      return out;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         val = {val[30:0], lfsr_bit()};
      end
      return val;
   endfunction

   // window offset is the address with bit 31 flipped, then the base is added
   function automatic zynq_shim_pkg::dram_req_s ref_remap(input zynq_shim_pkg::bp_req_s req,
                                                          input zynq_shim_pkg::csr_data_t base);
      zynq_shim_pkg::dram_req_s res;
      zynq_shim_pkg::paddr_t    offset;
      offset = {~req.addr[31], req.addr[30:0]};
      res.wr = req.wr;
      res.addr = offset + base;
      res.over_limit = (offset >= `ZS_MEM_LIMIT);
      return res;
   endfunction

   function automatic zynq_shim_pkg::region_t ref_region(input zynq_shim_pkg::bp_req_s req);
      return zynq_shim_pkg::region_t'(req.addr >> (`ZS_REGION_MSB - `ZS_REGION_W + 1));
   endfunction

   task automatic report_mismatch(input string msg);
      $display("[FAIL] %0t: %s", $time, msg);
      errors++;
   endtask

   task automatic next_drive_slot();
      @(posedge aclk);
      #1;
   endtask

   task automatic write_reg(input zynq_shim_pkg::csr_addr_t a,
                            input zynq_shim_pkg::csr_data_t d);
      next_drive_slot();
      csr_wr_v = 1'b1;
      csr_addr = a;
      csr_wdata = d;
      next_drive_slot();
      csr_wr_v = 1'b0;
   endtask

   task automatic check_read(input zynq_shim_pkg::csr_addr_t a,
                             input zynq_shim_pkg::csr_data_t exp);
      next_drive_slot();
      csr_rd_addr = a;
      @(negedge aclk);
      checks++;
      if (csr_rdata !== exp) begin
         report_mismatch($sformatf("register %0d read 0x%08h, expected 0x%08h",
            a, csr_rdata, exp));
      end
   endtask

   task automatic check_core_reset(input logic bit0);
      @(negedge aclk);
      checks++;
      if (core_reset !== ~bit0) begin
         report_mismatch($sformatf("core_reset_o is %b with register 0 bit 0 at %b",
            core_reset, bit0));
      end
   endtask

   // caller is at a drive slot, valid stays high on return
   task automatic send_request(input zynq_shim_pkg::bp_req_s req);
      bp_req_v = 1'b1;
      bp_req = req;
      @(negedge aclk);
      while (!bp_req_ready) begin
         @(negedge aclk);
      end
      next_drive_slot();
   endtask

   // the host takes about every other cycle so the FIFO fills up at times
   always @(posedge aclk) begin
      #1;
      if (rand_ready_en) begin
         dram_req_ready = rand_bits(1);
      end else begin
         dram_req_ready = 1'b1;
      end
   end

   // transfers are judged mid-cycle, when every handshake signal has settled
   always @(negedge aclk) begin
      if (arst_n) begin
         if (bp_req_v && bp_req_ready) begin
            exp_q.push_back(ref_remap(bp_req, base_val));
            region_q.push_back(ref_region(bp_req));
            accepted++;
         end
         if (dram_req_v && dram_req_ready) begin
            out_count++;
            if (exp_q.size() == 0) begin
               $display("error at %0t: DRAM request sent with none outstanding", $time);
               errors++;
            end else begin
               exp_req = exp_q.pop_front();
               exp_region = region_q.pop_front();
               checks++;
               if (dram_req.addr !== exp_req.addr || dram_req.wr !== exp_req.wr) begin
                  report_mismatch($sformatf(
                     "request %0d sent addr 0x%08h wr %b, expected 0x%08h wr %b",
                     out_count, dram_req.addr, dram_req.wr, exp_req.addr, exp_req.wr));
               end
               if (dram_req.over_limit !== exp_req.over_limit) begin
                  report_mismatch($sformatf("request %0d over_limit %b, expected %b",
                     out_count, dram_req.over_limit, exp_req.over_limit));
               end
               exp_profile[exp_region] = 1'b1;
            end
         end
      end
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("timeout: the run did not finish in %0d cycles", WATCHDOG_CYCLES);
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      zynq_shim_pkg::bp_req_s req;
      int gap;
      aclk = 1'b0;
      arst_n = 1'b0;
      csr_wr_v = 1'b0;
      csr_addr = '0;
      csr_wdata = '0;
      csr_rd_addr = '0;
      bp_req_v = 1'b0;
      bp_req = '0;
      dram_req_ready = 1'b0;
      rand_ready_en = 1'b0;
      base_val = '0;
      exp_profile = '0;
      errors = 0;
      checks = 0;
      accepted = 0;
      out_count = 0;
      repeat (RESET_CYCLES) @(posedge aclk);
      #1;
      arst_n = 1'b1;

      @(negedge aclk);
      checks++;
      if (dram_req_v !== 1'b0 || core_reset !== 1'b1) begin
         report_mismatch("after reset dram_req_v_o must be low and core_reset_o high");
      end
      for (int i = 0; i < 8; i++) begin
         check_read(zynq_shim_pkg::csr_addr_t'(i), '0);
      end

      write_reg(`ZS_CSR_RESET, 32'h0000_0001);
      check_core_reset(1'b1);
      check_read(`ZS_CSR_RESET, 32'h0000_0001);
      write_reg(`ZS_CSR_ALLOC, 32'h0000_0001);
      check_read(`ZS_CSR_ALLOC, 32'h0000_0001);
      base_val = 32'h1A00_0000;
      write_reg(`ZS_CSR_BASE, base_val);
      check_read(`ZS_CSR_BASE, base_val);
      write_reg(3'd3, 32'hFFFF_FFFF);
      check_read(3'd3, '0);
      write_reg(`ZS_CSR_RESET, 32'h0000_00F0);
      check_core_reset(1'b0);
      check_read(`ZS_CSR_RESET, 32'h0000_00F0);
      write_reg(`ZS_CSR_RESET, 32'h0000_0001);
      check_core_reset(1'b1);

      rand_ready_en = 1'b1;
      next_drive_slot();
      for (int i = 0; i < NUM_REQ; i++) begin
         gap = rand_bits(1) ? 0 : int'(rand_bits(2));
         if (gap > 0) begin
            bp_req_v = 1'b0;
            repeat (gap) next_drive_slot();
         end
         req.wr = rand_bits(1);
         req.addr = {3'b100, 29'(rand_bits(29))};
         send_request(req);
      end
      bp_req_v = 1'b0;
      wait (out_count >= NUM_REQ);
      rand_ready_en = 1'b0;
      repeat (10) @(posedge aclk);
      checks++;
      if (accepted != NUM_REQ || out_count != NUM_REQ || exp_q.size() != 0) begin
         report_mismatch($sformatf("%0d requests accepted and %0d sent out of %0d",
            accepted, out_count, NUM_REQ));
      end

      for (int w = 0; w < 4; w++) begin
         check_read(zynq_shim_pkg::csr_addr_t'(`ZS_CSR_PROF0 + w), exp_profile[w*32 +: 32]);
      end
      write_reg(`ZS_CSR_RESET, 32'h0000_0000);
      check_core_reset(1'b0);
      exp_profile = '0;
      write_reg(`ZS_CSR_RESET, 32'h0000_0001);
      for (int w = 0; w < 4; w++) begin
         check_read(zynq_shim_pkg::csr_addr_t'(`ZS_CSR_PROF0 + w), exp_profile[w*32 +: 32]);
      end

      $display("checks: %0d  errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* build.f */
+incdir+design
design/zynq_shim_pkg.sv
design/ps_csr_regs.sv
design/mem_req_intake.sv
design/req_fifo.sv
design/dram_remap.sv
design/zynq_dram_shim.sv
verif/zynq_dram_shim_asserts.sv
verif/zynq_dram_shim_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the shim testbench with Verilator.
# The run passes only if the simulation prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module zynq_dram_shim_tb -Mdir obj_dir -f build.f \
   || { echo "verilator build failed"; exit 1; }

sim_out="$(./obj_dir/Vzynq_dram_shim_tb)"
echo "$sim_out"

echo "$sim_out" | grep -q "TEST PASSED" && exit 0 || exit 1
